// File: flist.f
+incdir+test
design/kdi_pkg.sv
design/kdi_req_arbiter.sv
design/kdi_ctrl_fsm.sv
design/kdi_key_regs.sv
design/kdi_top.sv
test/kdi_tb.sv

// File: run.sh
#!/bin/sh
# Build the key derivation testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps -Wno-fatal \
  --top-module kdi_tb -f flist.f --Mdir obj_dir -o kdi_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/kdi_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

echo "Simulation passed"
exit 0

// File: test/kdi_tb_model.svh
// Pseudo-random source, digest datapath model and key reference, included inside the testbench

  // 16-bit Galois LFSR state
  logic [15:0] lfsr_q = 16'd17531;

  // One LFSR step per returned bit, first bit ends up in the MSB
  function automatic logic [63:0] lfsr_bits(input int n);
    logic [63:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b      = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (b) begin
        lfsr_q = lfsr_q ^ 16'hb400;
      end
      r = {r[62:0], b};
    end
    return r;
  endfunction

  // Initial digest state per datapath constant index
  function automatic block_t digest_iv(input digest_sel_t sel);
    case (sel)
      FlashDataSel: return 64'h243f_6a88_85a3_08d3;
      FlashAddrSel: return 64'h1319_8a2e_0370_7344;
      SramDataSel:  return 64'ha409_3822_299f_31d0;
      default:      return 64'h082e_fa98_ec4e_6c89;
    endcase
  endfunction

  // One digest round over the stored block and the new block
  function automatic block_t digest_mix(input block_t st, input block_t stored,
                                        input block_t blk);
    block_t t;
    t = st ^ stored;
    // Rotate left by 13
    t = {t[50:0], t[63:51]};
    return t + (blk ^ 64'h9e37_79b9_7f4a_7c15);
  endfunction

  // Expected key, two digests over seed pairs 0/1 and 2/3
  function automatic key_t expected_key(input seed_t seed, input logic seed_valid,
                                        input digest_sel_t sel, input logic ingest,
                                        input logic [4*BlockWidth-1:0] ent);
    seed_t  s;
    block_t st;
    key_t   k;
    s = seed_valid ? seed : '0;
    k = '0;
    for (int h = 0; h < 2; h++) begin
      st = digest_iv(sel);
      st = digest_mix(st, s[BlockWidth*(2*h) +: BlockWidth],
                      s[BlockWidth*(2*h+1) +: BlockWidth]);
      // Entropy words 2h and 2h+1 go into digest h
      if (ingest) begin
        st = digest_mix(st, ent[BlockWidth*(2*h) +: BlockWidth],
                        ent[BlockWidth*(2*h+1) +: BlockWidth]);
      end
      k[BlockWidth*h +: BlockWidth] = st;
    end
    return k;
  endfunction

// File: test/kdi_tb.sv
// Testbench for kdi_top with requester stimulus, mutex, digest and EDN responders and a checker
`timescale 1ns/100ps

module kdi_tb;

  import kdi_pkg::*;

  localparam int NumSramSlots = 2;
  // Flash data, flash address, then the memory slots
  localparam int NumReq       = 2 + NumSramSlots;
  localparam int Timeout      = 2000;

  logic                    clk_i, rst_ni, kdi_en_i, escalate_i, seed_valid_i;
  logic [NumReq-1:0]       req_vec;
  wire  [NumReq-1:0]       ack_vec;
  seed_t                   flash_data_seed_i, flash_addr_seed_i;
  logic [2*BlockWidth-1:0] sram_seed_i;
  key_t                    key_o;
  nonce_t                  nonce_o;
  logic                    seed_valid_o, fsm_err_o;
  logic                    scrmbl_mtx_req_o, scrmbl_mtx_gnt_i;
  scrmbl_cmd_e             scrmbl_cmd_o;
  digest_sel_t             scrmbl_sel_o;
  block_t                  scrmbl_data_o, scrmbl_data_i, edn_data_i;
  logic                    scrmbl_valid_o, scrmbl_ready_i, scrmbl_valid_i;
  logic                    edn_req_o, edn_ack_i;

  // EDN words handed out during the current derivation
  block_t                  edn_log [$];
  nonce_t                  exp_nonce;
  int                      ack_count;

  `include "kdi_tb_model.svh"

  kdi_top #(
    .NumSramSlots(NumSramSlots)
  ) u_dut (
    .clk_i, .rst_ni, .kdi_en_i, .escalate_i, .fsm_err_o,
    .flash_data_req_i (req_vec[0]),
    .flash_addr_req_i (req_vec[1]),
    .sram_req_i       (req_vec[NumReq-1:2]),
    .flash_data_ack_o (ack_vec[0]),
    .flash_addr_ack_o (ack_vec[1]),
    .sram_ack_o       (ack_vec[NumReq-1:2]),
    .key_o, .nonce_o, .seed_valid_o, .seed_valid_i,
    .flash_data_seed_i, .flash_addr_seed_i, .sram_seed_i,
    .scrmbl_mtx_req_o, .scrmbl_mtx_gnt_i, .scrmbl_cmd_o, .scrmbl_sel_o, .scrmbl_data_o,
    .scrmbl_valid_o, .scrmbl_ready_i, .scrmbl_valid_i, .scrmbl_data_i,
    .edn_req_o, .edn_ack_i, .edn_data_i
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #10 clk_i = ~clk_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic compare(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  // Lowest acked requester, -1 if none
  function automatic int acked_idx();
    int idx;
    idx = -1;
    for (int i = NumReq - 1; i >= 0; i--) begin
      if (ack_vec[i]) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  // Fresh seeds for all requesters, then raise the masked requests
  task automatic start_requests(input logic [NumReq-1:0] mask);
    seed_t fd, fa, sr;
    @(negedge clk_i);
    for (int b = 0; b < 4; b++) begin
      fd[BlockWidth*b +: BlockWidth] = lfsr_bits(64);
      fa[BlockWidth*b +: BlockWidth] = lfsr_bits(64);
      sr[BlockWidth*b +: BlockWidth] = lfsr_bits(64);
    end
    @(posedge clk_i);
    #2;
    flash_data_seed_i = fd;
    flash_addr_seed_i = fa;
    sram_seed_i       = sr[2*BlockWidth-1:0];
    req_vec           = req_vec | mask;
  endtask

  // Wait for any ack, then drop that request
  task automatic wait_ack(output int idx);
    int n;
    idx = -1;
    n   = 0;
    while (idx < 0) begin
      @(negedge clk_i);
      idx = acked_idx();
      n++;
      if (idx < 0 && n > Timeout) begin
        $display("Timeout while waiting for a request ack");
        stop_run();
      end
    end
    @(posedge clk_i);
    #2;
    req_vec[idx] = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Responders
  ////////////////////////////////////////////////////////////////////////////

  // Transfers are sampled at the falling edge, responses driven after the rising edge
  initial begin : responder
    int     mtx_wait, edn_wait, res_wait;
    logic   res_pend, fin_seen, edn_seen, mtx_req, edn_req;
    block_t st, stored;
    mtx_wait = 0;
    edn_wait = 0;
    res_wait = 0;
    res_pend = 1'b0;
    st       = '0;
    stored   = '0;
    forever begin
      @(negedge clk_i);
      fin_seen = 1'b0;
      if (scrmbl_valid_o && scrmbl_ready_i) begin
        case (scrmbl_cmd_o)
          DigestInit: st = digest_iv(scrmbl_sel_o);
          LoadBlock:  stored = scrmbl_data_o;
          Digest:     st = digest_mix(st, stored, scrmbl_data_o);
          default:    fin_seen = 1'b1;
        endcase
      end
      edn_seen = edn_req_o && edn_ack_i;
      if (edn_seen) begin
        edn_log.push_back(edn_data_i);
      end
      mtx_req = scrmbl_mtx_req_o;
      edn_req = edn_req_o;
      @(posedge clk_i);
      #2;
      scrmbl_ready_i = (lfsr_bits(2) != 64'd0);
      // Mutex granted after a random wait and released with the request
      if (!mtx_req) begin
        scrmbl_mtx_gnt_i = 1'b0;
        mtx_wait         = int'(lfsr_bits(2));
      end else if (mtx_wait == 0) begin
        scrmbl_mtx_gnt_i = 1'b1;
      end else begin
        mtx_wait--;
      end
      // EDN word pulse after a random wait
      edn_ack_i = 1'b0;
      if (edn_seen) begin
        edn_wait = int'(lfsr_bits(2));
      end else if (edn_req) begin
        if (edn_wait == 0) begin
          edn_ack_i  = 1'b1;
          edn_data_i = lfsr_bits(64);
        end else begin
          edn_wait--;
        end
      end
      // Digest result returns as a single-cycle pulse
      scrmbl_valid_i = 1'b0;
      if (res_pend) begin
        if (res_wait == 0) begin
          scrmbl_valid_i = 1'b1;
          scrmbl_data_i  = st;
          res_pend       = 1'b0;
        end else begin
          res_wait--;
        end
      end
      if (fin_seen) begin
        res_pend = 1'b1;
        res_wait = int'(lfsr_bits(2));
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checker
  ////////////////////////////////////////////////////////////////////////////

  initial begin : ack_check
    int                      idx, n_ent, n_words;
    logic                    two_words;
    seed_t                   seed;
    digest_sel_t             sel;
    logic [4*BlockWidth-1:0] ent;
    ack_count = 0;
    exp_nonce = NonceInitDefault;
    forever begin
      @(negedge clk_i);
      idx = acked_idx();
      if (idx >= 0) begin
        // Memory slots take four entropy words, flash address one nonce word
        n_ent     = (idx >= 2) ? 4 : 0;
        two_words = (idx != 1);
        n_words   = n_ent + (two_words ? 2 : 1);
        if (idx == 0) begin
          seed = flash_data_seed_i;
          sel  = FlashDataSel;
        end else if (idx == 1) begin
          seed = flash_addr_seed_i;
          sel  = FlashAddrSel;
        end else begin
          seed = {sram_seed_i, sram_seed_i};
          sel  = SramDataSel;
        end
        compare("edn word count", 128'(edn_log.size()), 128'(n_words));
        ent = '0;
        for (int i = 0; i < n_ent; i++) begin
          ent[BlockWidth*i +: BlockWidth] = edn_log[i];
        end
        exp_nonce[BlockWidth-1:0] = edn_log[n_ent];
        if (two_words) begin
          exp_nonce[2*BlockWidth-1:BlockWidth] = edn_log[n_ent+1];
        end
        compare("key_o", key_o, expected_key(seed, seed_valid_i, sel, idx >= 2, ent));
        compare("nonce_o", nonce_o, exp_nonce);
        compare("seed_valid_o", 128'(seed_valid_o), 128'(seed_valid_i));
        edn_log.delete();
        ack_count++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int idx, rr_ptr, n;
    rst_ni            = 1'b0;
    kdi_en_i          = 1'b0;
    escalate_i        = 1'b0;
    seed_valid_i      = 1'b1;
    req_vec           = '0;
    flash_data_seed_i = '0;
    flash_addr_seed_i = '0;
    sram_seed_i       = '0;
    scrmbl_mtx_gnt_i  = 1'b0;
    scrmbl_ready_i    = 1'b0;
    scrmbl_valid_i    = 1'b0;
    scrmbl_data_i     = '0;
    edn_ack_i         = 1'b0;
    edn_data_i        = '0;
    rr_ptr            = 0;
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // Engine ignores requests until enabled
    start_requests(4'b0001);
    for (int i = 0; i < 30; i++) begin
      @(negedge clk_i);
      if (ack_vec != '0 || edn_req_o || scrmbl_mtx_req_o) begin
        $display("Engine reacted to a request before it was enabled");
        stop_run();
      end
    end
    @(posedge clk_i);
    #2;
    kdi_en_i = 1'b1;
    @(posedge clk_i);
    #2;
    kdi_en_i = 1'b0;
    wait_ack(idx);
    compare("ack index", 128'(idx), 128'(0));

    // Flash address, then a memory slot with entropy
    start_requests(4'b0010);
    wait_ack(idx);
    compare("ack index", 128'(idx), 128'(1));
    start_requests(4'b0100);
    wait_ack(idx);
    compare("ack index", 128'(idx), 128'(2));

    // Invalid seed derives from zeros
    seed_valid_i = 1'b0;
    start_requests(4'b0001);
    wait_ack(idx);
    compare("ack index", 128'(idx), 128'(0));
    rr_ptr       = 1;
    seed_valid_i = 1'b1;

    // All at once, served from the requester just past the last one
    start_requests('1);
    for (int k = 0; k < NumReq; k++) begin
      wait_ack(idx);
      compare("ack index", 128'(idx), 128'(rr_ptr));
      rr_ptr = (idx + 1) % NumReq;
    end
    compare("ack count", 128'(ack_count), 128'(8));

    // Escalate in the middle of a derivation
    start_requests(4'b1000);
    n = 0;
    while (!scrmbl_mtx_req_o) begin
      @(negedge clk_i);
      n++;
      if (n > Timeout) begin
        $display("Timeout while waiting for the mutex request");
        stop_run();
      end
    end
    @(posedge clk_i);
    #2;
    escalate_i = 1'b1;
    @(negedge clk_i);
    compare("fsm_err_o", 128'(fsm_err_o), 128'(1));
    @(posedge clk_i);
    #2;
    escalate_i = 1'b0;
    for (int i = 0; i < Timeout; i++) begin
      @(negedge clk_i);
      compare("fsm_err_o", 128'(fsm_err_o), 128'(1));
      if (ack_vec != '0) begin
        $display("A request was acked after escalation");
        stop_run();
      end
    end
    $display("No errors");
    $finish;
  end

endmodule

// File: design/kdi_top.sv
// Key derivation top level joining the request arbiter, sequencer and output registers
`timescale 1ns/100ps

module kdi_top #(
  parameter int              NumSramSlots = 2,
  parameter kdi_pkg::key_t   KeyInit      = kdi_pkg::KeyInitDefault,
  parameter kdi_pkg::nonce_t NonceInit    = kdi_pkg::NonceInitDefault
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             kdi_en_i,
  input  logic                             escalate_i,
  output logic                             fsm_err_o,
  // Requesters
  input  logic                             flash_data_req_i,
  input  logic                             flash_addr_req_i,
  input  logic [NumSramSlots-1:0]          sram_req_i,
  output logic                             flash_data_ack_o,
  output logic                             flash_addr_ack_o,
  output logic [NumSramSlots-1:0]          sram_ack_o,
  output kdi_pkg::key_t                    key_o,
  output kdi_pkg::nonce_t                  nonce_o,
  output logic                             seed_valid_o,
  // Seeds
  input  logic                             seed_valid_i,
  input  kdi_pkg::seed_t                   flash_data_seed_i,
  input  kdi_pkg::seed_t                   flash_addr_seed_i,
  input  logic [2*kdi_pkg::BlockWidth-1:0] sram_seed_i,
  // Mutex and digest datapath
  output logic                             scrmbl_mtx_req_o,
  input  logic                             scrmbl_mtx_gnt_i,
  output kdi_pkg::scrmbl_cmd_e             scrmbl_cmd_o,
  output kdi_pkg::digest_sel_t             scrmbl_sel_o,
  output kdi_pkg::block_t                  scrmbl_data_o,
  output logic                             scrmbl_valid_o,
  input  logic                             scrmbl_ready_i,
  input  logic                             scrmbl_valid_i,
  input  kdi_pkg::block_t                  scrmbl_data_i,
  // EDN
  output logic                             edn_req_o,
  input  logic                             edn_ack_i,
  input  kdi_pkg::block_t                  edn_data_i
);

  import kdi_pkg::*;

  logic       idle, done, req_valid;
  kdi_cfg_t   cfg;
  seed_t      seed;
  logic [1:0] seed_idx;
  logic       entropy_idx, entropy_sel;
  logic       key_we, nonce_we, seed_valid_we;

  kdi_req_arbiter #(
    .NumSramSlots(NumSramSlots)
  ) u_arb (
    .clk_i,
    .rst_ni,
    .flash_data_req_i,
    .flash_addr_req_i,
    .sram_req_i,
    .flash_data_ack_o,
    .flash_addr_ack_o,
    .sram_ack_o,
    .flash_data_seed_i,
    .flash_addr_seed_i,
    .sram_seed_i,
    .idle_i       (idle),
    .done_i       (done),
    .req_valid_o  (req_valid),
    .cfg_o        (cfg),
    .digest_sel_o (scrmbl_sel_o),
    .seed_o       (seed)
  );

  kdi_ctrl_fsm u_fsm (
    .clk_i,
    .rst_ni,
    .kdi_en_i,
    .escalate_i,
    .req_valid_i     (req_valid),
    .cfg_i           (cfg),
    .idle_o          (idle),
    .done_o          (done),
    .fsm_err_o,
    .scrmbl_mtx_req_o,
    .scrmbl_mtx_gnt_i,
    .scrmbl_cmd_o,
    .scrmbl_valid_o,
    .scrmbl_ready_i,
    .scrmbl_valid_i,
    .edn_req_o,
    .edn_ack_i,
    .seed_idx_o      (seed_idx),
    .entropy_idx_o   (entropy_idx),
    .entropy_sel_o   (entropy_sel),
    .key_we_o        (key_we),
    .nonce_we_o      (nonce_we),
    .seed_valid_we_o (seed_valid_we)
  );

  kdi_key_regs #(
    .KeyInit   (KeyInit),
    .NonceInit (NonceInit)
  ) u_regs (
    .clk_i,
    .rst_ni,
    .seed_i          (seed),
    .seed_valid_i,
    .seed_idx_i      (seed_idx),
    .entropy_idx_i   (entropy_idx),
    .entropy_sel_i   (entropy_sel),
    .key_we_i        (key_we),
    .nonce_we_i      (nonce_we),
    .seed_valid_we_i (seed_valid_we),
    .scrmbl_data_i,
    .edn_data_i,
    .scrmbl_data_o,
    .key_o,
    .nonce_o,
    .seed_valid_o
  );

endmodule

// File: design/kdi_key_regs.sv
// Key, nonce and seed-valid output registers with the digest input block mux
`timescale 1ns/100ps

module kdi_key_regs #(
  parameter kdi_pkg::key_t   KeyInit   = kdi_pkg::KeyInitDefault,
  parameter kdi_pkg::nonce_t NonceInit = kdi_pkg::NonceInitDefault
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Granted seed and its valid flag
  input  kdi_pkg::seed_t   seed_i,
  input  logic             seed_valid_i,
  // Controls from the sequencer
  input  logic [1:0]       seed_idx_i,
  input  logic             entropy_idx_i,
  input  logic             entropy_sel_i,
  input  logic             key_we_i,
  input  logic             nonce_we_i,
  input  logic             seed_valid_we_i,
  // Digest result and EDN word
  input  kdi_pkg::block_t  scrmbl_data_i,
  input  kdi_pkg::block_t  edn_data_i,
  output kdi_pkg::block_t  scrmbl_data_o,
  // Shared by all requesters
  output kdi_pkg::key_t    key_o,
  output kdi_pkg::nonce_t  nonce_o,
  output logic             seed_valid_o
);

  import kdi_pkg::*;

  key_t   key_q;
  nonce_t nonce_q;
  logic   seed_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_out_regs
    if (!rst_ni) begin
      key_q        <= KeyInit;
      nonce_q      <= NonceInit;
      seed_valid_q <= 1'b0;
    end else begin
      // First digest fills the low half, second digest the high half
      if (key_we_i) begin
        key_q[BlockWidth*seed_idx_i[1] +: BlockWidth] <= scrmbl_data_i;
      end
      if (nonce_we_i) begin
        nonce_q[BlockWidth*entropy_idx_i +: BlockWidth] <= edn_data_i;
      end
      if (seed_valid_we_i) begin
        seed_valid_q <= seed_valid_i;
      end
    end
  end

  // Entropy words are read back out of the nonce register
  always_comb begin : p_block_sel
    if (entropy_sel_i) begin
      scrmbl_data_o = nonce_q[BlockWidth*entropy_idx_i +: BlockWidth];
    end else if (seed_valid_i) begin
      scrmbl_data_o = seed_i[BlockWidth*seed_idx_i +: BlockWidth];
    end else begin
      // Invalid seed derives from all zeros
      scrmbl_data_o = '0;
    end
  end

  assign key_o        = key_q;
  assign nonce_o      = nonce_q;
  assign seed_valid_o = seed_valid_q;

  // Sequencer never writes key and nonce in the same cycle
  a_we_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(key_we_i && nonce_we_i));

endmodule

// File: design/kdi_ctrl_fsm.sv
// Key derivation sequencer driving the mutex, digest datapath commands and EDN requests
`timescale 1ns/100ps

module kdi_ctrl_fsm (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 kdi_en_i,
  input  logic                 escalate_i,
  // Arbiter side
  input  logic                 req_valid_i,
  input  kdi_pkg::kdi_cfg_t    cfg_i,
  output logic                 idle_o,
  output logic                 done_o,
  output logic                 fsm_err_o,
  // Datapath mutex
  output logic                 scrmbl_mtx_req_o,
  input  logic                 scrmbl_mtx_gnt_i,
  // Digest datapath
  output kdi_pkg::scrmbl_cmd_e scrmbl_cmd_o,
  output logic                 scrmbl_valid_o,
  input  logic                 scrmbl_ready_i,
  input  logic                 scrmbl_valid_i,
  // EDN
  output logic                 edn_req_o,
  input  logic                 edn_ack_i,
  // Register and block select controls
  output logic [1:0]           seed_idx_o,
  output logic                 entropy_idx_o,
  output logic                 entropy_sel_o,
  output logic                 key_we_o,
  output logic                 nonce_we_o,
  output logic                 seed_valid_we_o
);

  import kdi_pkg::*;

  typedef enum logic [3:0] {
    Reset,
    Idle,
    DigClr,
    DigLoad,
    FetchEntropy,
    DigEntropy,
    DigFin,
    DigWait,
    FetchNonce,
    Finish,
    Error
  } state_e;

  state_e     state_d, state_q;
  // Seed block index, bit 1 also picks the key half
  logic [1:0] seed_cnt_d, seed_cnt_q;
  logic       entropy_cnt_d, entropy_cnt_q;
  logic       edn_req_d, edn_req_q;
  logic       edn_done;

  assign edn_done      = edn_req_q & edn_ack_i;
  assign edn_req_o     = edn_req_q;
  assign seed_idx_o    = seed_cnt_q;
  assign entropy_idx_o = entropy_cnt_q;
  assign idle_o        = (state_q == Idle);

  always_comb begin : p_fsm
    state_d       = state_q;
    seed_cnt_d    = seed_cnt_q;
    entropy_cnt_d = entropy_cnt_q;
    // A raised EDN request stays up until acked, whatever the state
    edn_req_d        = edn_req_q & ~edn_ack_i;
    done_o           = 1'b0;
    fsm_err_o        = 1'b0;
    scrmbl_mtx_req_o = 1'b0;
    scrmbl_cmd_o     = LoadBlock;
    scrmbl_valid_o   = 1'b0;
    entropy_sel_o    = 1'b0;
    key_we_o         = 1'b0;
    nonce_we_o       = 1'b0;
    seed_valid_we_o  = 1'b0;

    unique case (state_q)
      // Hold here until the OTP partitions are up
      Reset: begin
        if (kdi_en_i) begin
          state_d = Idle;
        end
      end
      Idle: begin
        if (req_valid_i) begin
          state_d       = DigClr;
          seed_cnt_d    = '0;
          entropy_cnt_d = 1'b0;
        end
      end
      // Grab the mutex, then reset the digest to its initial value
      DigClr: begin
        scrmbl_mtx_req_o = 1'b1;
        scrmbl_valid_o   = scrmbl_mtx_gnt_i;
        scrmbl_cmd_o     = DigestInit;
        if (scrmbl_mtx_gnt_i && scrmbl_ready_i) begin
          state_d = DigLoad;
        end
      end
      // Even block is loaded, odd block triggers the digest round
      DigLoad: begin
        scrmbl_mtx_req_o = 1'b1;
        scrmbl_valid_o   = 1'b1;
        if (seed_cnt_q[0]) begin
          scrmbl_cmd_o = Digest;
          if (scrmbl_ready_i) begin
            state_d = cfg_i[0] ? FetchEntropy : DigFin;
          end
        end else if (scrmbl_ready_i) begin
          seed_cnt_d = seed_cnt_q + 1'b1;
        end
      end
      // Two EDN words, parked in the nonce register
      FetchEntropy: begin
        scrmbl_mtx_req_o = 1'b1;
        edn_req_d        = ~edn_done;
        if (edn_done) begin
          nonce_we_o    = 1'b1;
          entropy_cnt_d = ~entropy_cnt_q;
          if (entropy_cnt_q) begin
            state_d = DigEntropy;
          end
        end
      end
      DigEntropy: begin
        scrmbl_mtx_req_o = 1'b1;
        scrmbl_valid_o   = 1'b1;
        entropy_sel_o    = 1'b1;
        scrmbl_cmd_o     = entropy_cnt_q ? Digest : LoadBlock;
        if (scrmbl_ready_i) begin
          entropy_cnt_d = ~entropy_cnt_q;
          if (entropy_cnt_q) begin
            state_d = DigFin;
          end
        end
      end
      DigFin: begin
        scrmbl_mtx_req_o = 1'b1;
        scrmbl_valid_o   = 1'b1;
        scrmbl_cmd_o     = DigestFinalize;
        if (scrmbl_ready_i) begin
          state_d = DigWait;
        end
      end
      // Result lands in key half seed_cnt_q[1]
      DigWait: begin
        scrmbl_mtx_req_o = 1'b1;
        if (scrmbl_valid_i) begin
          key_we_o = 1'b1;
          if (!seed_cnt_q[1]) begin
            seed_cnt_d = seed_cnt_q + 1'b1;
            state_d    = DigClr;
          end else begin
            seed_cnt_d      = '0;
            seed_valid_we_o = 1'b1;
            state_d         = FetchNonce;
          end
        end
      end
      // Mutex already released here
      FetchNonce: begin
        edn_req_d = ~edn_done;
        if (edn_done) begin
          nonce_we_o = 1'b1;
          if (entropy_cnt_q == cfg_i[1]) begin
            entropy_cnt_d = 1'b0;
            state_d       = Finish;
          end else begin
            entropy_cnt_d = 1'b1;
          end
        end
      end
      Finish: begin
        done_o  = 1'b1;
        state_d = Idle;
      end
      // Terminal, only a reset leaves it
      Error: begin
        fsm_err_o = 1'b1;
      end
      default: begin
        state_d   = Error;
        fsm_err_o = 1'b1;
      end
    endcase

    if (escalate_i) begin
      state_d   = Error;
      fsm_err_o = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q       <= Reset;
      seed_cnt_q    <= '0;
      entropy_cnt_q <= 1'b0;
      edn_req_q     <= 1'b0;
    end else begin
      state_q       <= state_d;
      seed_cnt_q    <= seed_cnt_d;
      entropy_cnt_q <= entropy_cnt_d;
      edn_req_q     <= edn_req_d;
    end
  end

  // EDN req/ack protocol holds even across escalation
  a_edn_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    edn_req_o && !edn_ack_i |=> edn_req_o);

  // No datapath command unless the mutex is requested and granted
  a_valid_mtx: assert property (@(posedge clk_i) disable iff (!rst_ni)
    scrmbl_valid_o |-> scrmbl_mtx_req_o && scrmbl_mtx_gnt_i);

endmodule

// File: design/kdi_req_arbiter.sv
// Round-robin arbiter that picks one key request and holds its configuration for the sequencer
`timescale 1ns/100ps

module kdi_req_arbiter #(
  parameter int NumSramSlots = 2
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Level requests, each held until its ack pulse
  input  logic                             flash_data_req_i,
  input  logic                             flash_addr_req_i,
  input  logic [NumSramSlots-1:0]          sram_req_i,
  output logic                             flash_data_ack_o,
  output logic                             flash_addr_ack_o,
  output logic [NumSramSlots-1:0]          sram_ack_o,
  // Seeds from the OTP partitions
  input  kdi_pkg::seed_t                   flash_data_seed_i,
  input  kdi_pkg::seed_t                   flash_addr_seed_i,
  input  logic [2*kdi_pkg::BlockWidth-1:0] sram_seed_i,
  // Sequencer side
  input  logic                             idle_i,
  input  logic                             done_i,
  output logic                             req_valid_o,
  output kdi_pkg::kdi_cfg_t                cfg_o,
  output kdi_pkg::digest_sel_t             digest_sel_o,
  output kdi_pkg::seed_t                   seed_o
);

  import kdi_pkg::*;

  // Flash data, flash address, then the memory slots
  localparam int NumReq   = 2 + NumSramSlots;
  localparam int IdxWidth = $clog2(NumReq);

  // Entropy bit 0, last nonce word index bit 1
  localparam kdi_cfg_t FlashDataCfg = 2'b10;
  localparam kdi_cfg_t FlashAddrCfg = 2'b00;
  localparam kdi_cfg_t SramCfg      = 2'b11;

  logic [NumReq-1:0] req, ack;
  seed_t             seeds [NumReq];
  kdi_cfg_t          cfgs  [NumReq];
  digest_sel_t       sels  [NumReq];

  assign req = {sram_req_i, flash_addr_req_i, flash_data_req_i};

  assign seeds[0] = flash_data_seed_i;
  assign cfgs[0]  = FlashDataCfg;
  assign sels[0]  = FlashDataSel;
  assign seeds[1] = flash_addr_seed_i;
  assign cfgs[1]  = FlashAddrCfg;
  assign sels[1]  = FlashAddrSel;

  // All memory slots share one seed, repeated to fill both digests
  for (genvar k = 0; k < NumSramSlots; k++) begin : gen_sram
    assign seeds[2+k] = {sram_seed_i, sram_seed_i};
    assign cfgs[2+k]  = SramCfg;
    assign sels[2+k]  = SramDataSel;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Round-robin pick
  ////////////////////////////////////////////////////////////////////////////

  logic [IdxWidth-1:0] ptr_q, pick, gnt_idx_q;
  logic                pick_valid, gnt_valid_q, grant;
  kdi_cfg_t            cfg_q;
  digest_sel_t         sel_q;

  // Walk from the far end so the requester nearest the pointer wins
  always_comb begin : p_pick
    int unsigned idx;
    pick       = '0;
    pick_valid = 1'b0;
    for (int i = NumReq - 1; i >= 0; i--) begin
      idx = (int'(ptr_q) + i) % NumReq;
      if (req[idx]) begin
        pick       = IdxWidth'(idx);
        pick_valid = 1'b1;
      end
    end
  end

  // New grants only while the engine sits idle
  assign grant = idle_i & ~gnt_valid_q & pick_valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_gnt
    if (!rst_ni) begin
      gnt_valid_q <= 1'b0;
      gnt_idx_q   <= '0;
      ptr_q       <= '0;
    end else if (done_i && gnt_valid_q) begin
      gnt_valid_q <= 1'b0;
      // Priority moves just past the requester that was served
      ptr_q <= (gnt_idx_q == IdxWidth'(NumReq - 1)) ? '0 : gnt_idx_q + 1'b1;
    end else if (grant) begin
      gnt_valid_q <= 1'b1;
      gnt_idx_q   <= pick;
    end
  end

  always_ff @(posedge clk_i) begin : p_cfg
    if (grant) begin
      cfg_q <= cfgs[pick];
      sel_q <= sels[pick];
    end
  end

  assign req_valid_o  = gnt_valid_q;
  assign cfg_o        = cfg_q;
  assign digest_sel_o = sel_q;
  assign seed_o       = seeds[gnt_idx_q];

  // Ack pulse to the granted requester in the done cycle
  assign ack = {NumReq{done_i & gnt_valid_q}} & (NumReq'(1) << gnt_idx_q);

  assign flash_data_ack_o = ack[0];
  assign flash_addr_ack_o = ack[1];
  assign sram_ack_o       = ack[NumReq-1:2];

  // At most one ack, and only to a requester still holding its request
  a_ack_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(ack) && ((ack & ~req) == '0));

endmodule

// File: design/kdi_pkg.sv
// Widths, vector types and encodings shared by the key derivation RTL and its testbench
package kdi_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // One digest block, also one EDN word
  parameter int BlockWidth = 64;
  parameter int KeyWidth   = 128;
  // EDN words held in the nonce register
  parameter int NonceWords = 2;

  typedef logic [BlockWidth-1:0]            block_t;
  // Two seed blocks go into each digest, two digests per key
  typedef logic [4*BlockWidth-1:0]          seed_t;
  typedef logic [KeyWidth-1:0]              key_t;
  typedef logic [NonceWords*BlockWidth-1:0] nonce_t;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath encodings
  ////////////////////////////////////////////////////////////////////////////

  // Index of the initial-value constant inside the digest datapath
  typedef logic [1:0] digest_sel_t;

  parameter digest_sel_t FlashDataSel = 2'd0;
  parameter digest_sel_t FlashAddrSel = 2'd1;
  parameter digest_sel_t SramDataSel  = 2'd2;

  typedef enum logic [1:0] {
    LoadBlock,
    DigestInit,
    Digest,
    DigestFinalize
  } scrmbl_cmd_e;

  // Bit 0 ingests entropy, bit 1 holds the last nonce word index
  typedef logic [1:0] kdi_cfg_t;

  // Output values seen before the first derivation completes
  parameter key_t   KeyInitDefault   = 128'h5a3c_91e7_0b4d_62f8_c713_2ea9_84d6_1f05;
  parameter nonce_t NonceInitDefault = 128'h0e6b_d241_7fa3_58c9_3b90_e6d4_a215_7c8f;

endpackage
